// File: hw/char_slot.sv
module char_slot import morse_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  load_i,
  input  logic  clear_i,
  input  seg_t  seg_i,
  input  code_t code_i,
  output seg_t  seg_o,
  output code_t code_o
);

  seg_t  seg_q;
  code_t code_q;

  // Load and clear never arrive together
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      seg_q  <= SEG_BLANK;
      code_q <= CODE_EMPTY;
    end
    else if (load_i)
    begin
      seg_q  <= seg_i;
      code_q <= code_i;
    end
    else if (clear_i)
    begin
      seg_q  <= SEG_BLANK;   // back to dark
      code_q <= CODE_EMPTY;
    end
  end

  assign seg_o  = seg_q;
  assign code_o = code_q;

endmodule

// File: hw/entry_ctrl.sv
module entry_ctrl import morse_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tick_i,
  input  logic                 enable_i,
  input  logic                 press_i,
  input  logic                 backspace_i,
  output logic [NUM_SLOTS-1:0] load_o,
  output logic [NUM_SLOTS-1:0] clear_o,
  output count_t               count_o
);

  typedef enum logic [1:0]
  {
    ACT_IDLE,
    ACT_APPEND,
    ACT_DELETE
  } action_t;

  count_t  count_q;
  action_t action;
  logic    sample;
  logic    full;
  logic    empty;

  ////////////////////
  // Decision
  ////////////////////

  assign sample = tick_i & enable_i;
  assign full   = (count_q == count_t'(NUM_SLOTS));
  assign empty  = (count_q == '0);

  // Press has priority
  always_comb
  begin
    action = ACT_IDLE;
    if (sample)
    begin
      if (press_i && !full)
        action = ACT_APPEND;
      else if (backspace_i && !empty)
        action = ACT_DELETE;
    end
  end

  ////////////////////
  // Character count
  ////////////////////

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      count_q <= '0;
    end
    else
    begin
      case (action)
        ACT_APPEND: count_q <= count_q + 1'b1;
        ACT_DELETE: count_q <= count_q - 1'b1;
        default:    count_q <= count_q;
      endcase
    end
  end

  assign count_o = count_q;

  ////////////////////
  // Slot strobes
  ////////////////////

  // Append writes slot count, delete blanks slot count-1
  always_comb
  begin
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      load_o[i]  = (action == ACT_APPEND) && (count_q == count_t'(i));
      clear_o[i] = (action == ACT_DELETE) && (count_q == count_t'(i + 1));
    end
  end

endmodule

// File: hw/key_tick_gen.sv
module key_tick_gen #(
  parameter int TICK_DIV_BITS = 25
) (
  input  logic clk,
  input  logic rst,
  output logic tick_o
);

  logic [TICK_DIV_BITS-1:0] div_cnt;

  // Free-running divider
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // One pulse per wrap of the divider
  assign tick_o = &div_cnt;  // high in the last count before the wrap

endmodule

// File: hw/morse_entry_top.sv
module morse_entry_top import morse_pkg::*; #(
  parameter int TICK_DIV_BITS = 25
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable_i,
  input  logic              press_i,
  input  logic              backspace_i,
  input  seg_t              seg_i,
  output logic [DISP_W-1:0] display_o,
  output logic [MSG_W-1:0]  message_o,
  output count_t            count_o
);

  logic                 tick;
  logic [NUM_SLOTS-1:0] load;
  logic [NUM_SLOTS-1:0] clear;
  code_t                key_code;
  seg_t                 slot_seg  [NUM_SLOTS];
  code_t                slot_code [NUM_SLOTS];

  ////////////////////
  // Key sampling
  ////////////////////

  key_tick_gen #(
    .TICK_DIV_BITS (TICK_DIV_BITS)
  ) u_tick (
    .clk    (clk),
    .rst    (rst),
    .tick_o (tick)
  );

  seg_to_code u_code (
    .seg_i  (seg_i),
    .code_o (key_code)
  );

  entry_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .tick_i      (tick),
    .enable_i    (enable_i),
    .press_i     (press_i),
    .backspace_i (backspace_i),
    .load_o      (load),
    .clear_o     (clear),
    .count_o     (count_o)
  );

  ////////////////////
  // Character slots
  ////////////////////

  // Slot 0 is the first character typed, lowest bits of each bus
  for (genvar k = 0; k < NUM_SLOTS; k++)
  begin : g_slot
    char_slot u_slot (
      .clk     (clk),
      .rst     (rst),
      .load_i  (load[k]),
      .clear_i (clear[k]),
      .seg_i   (seg_i),
      .code_i  (key_code),
      .seg_o   (slot_seg[k]),
      .code_o  (slot_code[k])
    );

    assign display_o[k*SEG_W +: SEG_W]   = slot_seg[k];
    assign message_o[k*CODE_W +: CODE_W] = slot_code[k];
  end

endmodule

// File: hw/morse_pkg.sv
package morse_pkg;

  ////////////////////
  // Buffer geometry
  ////////////////////

  // Character positions in the buffer
  localparam int NUM_SLOTS = 8;

  // Seven segments plus decimal point
  localparam int SEG_W = 8;

  // Pulse code of one character, bit 0 sent first
  localparam int CODE_W = 17;

  // Enough bits to count 0 .. NUM_SLOTS
  localparam int COUNT_W = $clog2(NUM_SLOTS + 1);

  // Flattened output buses
  localparam int DISP_W = NUM_SLOTS * SEG_W;   // 64
  localparam int MSG_W  = NUM_SLOTS * CODE_W;  // 136

  ////////////////////
  // Types
  ////////////////////

  // Active-low segment pattern, bit 7 is the decimal point
  typedef logic [SEG_W-1:0] seg_t;

  // Pulse code, unused tail bits stay zero
  typedef logic [CODE_W-1:0] code_t;

  // Characters held
  typedef logic [COUNT_W-1:0] count_t;

  ////////////////////
  // Empty slot values
  ////////////////////

  // All segments off
  localparam seg_t SEG_BLANK = '1;

  // Nothing to send
  localparam code_t CODE_EMPTY = '0;

endpackage

// File: hw/seg_to_code.sv
module seg_to_code import morse_pkg::*; (
  input  seg_t  seg_i,
  output code_t code_o
);

  ////////////////////
  // Hex digit table
  ////////////////////

  // Patterns are active low, codes written bit 16 down to bit 0
  // so the first pulse sits at the right end of each literal
  always_comb
  begin
    case (seg_i)
      // Digits
      8'b1100_0000: code_o = 17'b00011011011011011;  // 0
      8'b1111_1001: code_o = 17'b00001101101101101;  // 1
      8'b1010_0100: code_o = 17'b00000110110110101;  // 2
      8'b1011_0000: code_o = 17'b00000011011010101;  // 3
      8'b1001_1001: code_o = 17'b00000001101010101;  // 4
      8'b1001_0010: code_o = 17'b00000000101010101;  // 5
      8'b1000_0010: code_o = 17'b00000001010101011;  // 6
      8'b1111_1000: code_o = 17'b00000010101011011;  // 7
      8'b1000_0000: code_o = 17'b00000101011011011;  // 8
      8'b1001_0000: code_o = 17'b00001011011011011;  // 9

      // Letters, mixed case as shown on the display
      8'b1000_1000: code_o = 17'b00000000000001101;  // A
      8'b1000_0011: code_o = 17'b00000000010101011;  // b
      8'b1100_0110: code_o = 17'b00000000101101011;  // C
      8'b1010_0001: code_o = 17'b00000000000101011;  // d
      8'b1000_0110: code_o = 17'b00000000000000001;  // E
      8'b1000_1110: code_o = 17'b00000000010110101;  // F

      // Not a hex digit, slot keeps segments only
      default:      code_o = CODE_EMPTY;
    endcase
  end

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_morse_entry

# Result is read from the log below
./obj_dir/Vtb_morse_entry > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0

// File: sim/tb_morse_entry.sv
module tb_morse_entry import morse_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TICK_BITS    = 3;
  localparam int TICK_PERIOD  = 1 << TICK_BITS;  // 8 cycles
  localparam int RESET_CYCLES = 4;
  localparam int WAIT_LIMIT   = 32;
  localparam int RANDOM_STEPS = 400;

  logic              clk;
  logic              rst;
  logic              enable_i;
  logic              press_i;
  logic              backspace_i;
  seg_t              seg_i;
  logic [DISP_W-1:0] display_o;
  logic [MSG_W-1:0]  message_o;
  count_t            count_o;

  integer seed;
  string  test_name;

  // Hex digit patterns and their pulse codes
  seg_t  hex_seg  [16];
  code_t hex_code [16];
  seg_t  order    [16];

  // Reference model of the buffer
  seg_t  model_seg  [NUM_SLOTS];
  code_t model_code [NUM_SLOTS];
  int    model_count;

  morse_entry_top #(
    .TICK_DIV_BITS (TICK_BITS)
  ) dut (
    .clk         (clk),
    .rst         (rst),
    .enable_i    (enable_i),
    .press_i     (press_i),
    .backspace_i (backspace_i),
    .seg_i       (seg_i),
    .display_o   (display_o),
    .message_o   (message_o),
    .count_o     (count_o)
  );

  always #2 clk = ~clk;

  ////////////////////
  // Model
  ////////////////////

  task automatic set_digit(int idx, seg_t seg, code_t code);
    hex_seg[idx]  = seg;
    hex_code[idx] = code;
  endtask

  task automatic init_code_table;
    set_digit(0,  8'hc0, 17'h036db);
    set_digit(1,  8'hf9, 17'h01b6d);
    set_digit(2,  8'ha4, 17'h00db5);
    set_digit(3,  8'hb0, 17'h006d5);
    set_digit(4,  8'h99, 17'h00355);
    set_digit(5,  8'h92, 17'h00155);
    set_digit(6,  8'h82, 17'h002ab);
    set_digit(7,  8'hf8, 17'h0055b);
    set_digit(8,  8'h80, 17'h00adb);
    set_digit(9,  8'h90, 17'h016db);
    set_digit(10, 8'h88, 17'h0000d);  // A
    set_digit(11, 8'h83, 17'h000ab);  // b
    set_digit(12, 8'hc6, 17'h0016b);  // C
    set_digit(13, 8'ha1, 17'h0002b);  // d
    set_digit(14, 8'h86, 17'h00001);  // E
    set_digit(15, 8'h8e, 17'h000b5);  // F
  endtask

  function automatic code_t lookup_code(seg_t seg);
    code_t code;
    code = '0;
    for (int i = 0; i < 16; i++)
    begin
      if (hex_seg[i] == seg)
        code = hex_code[i];
    end
    return code;
  endfunction

  function automatic logic is_hex(seg_t seg);
    logic found;
    found = 1'b0;
    for (int i = 0; i < 16; i++)
    begin
      if (hex_seg[i] == seg)
        found = 1'b1;
    end
    return found;
  endfunction

  task automatic clear_model;
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      model_seg[k]  = '1;  // dark slot
      model_code[k] = '0;
    end
    model_count = 0;
  endtask

  task automatic update_model(logic en, logic pr, logic bs, seg_t seg);
    if (en)
    begin
      if (pr && model_count < NUM_SLOTS)
      begin
        model_seg[model_count]  = seg;
        model_code[model_count] = lookup_code(seg);
        model_count++;
      end
      else if (bs && model_count > 0)
      begin
        model_count--;
        model_seg[model_count]  = '1;
        model_code[model_count] = '0;
      end
    end
  endtask

  ////////////////////
  // Random helpers
  ////////////////////

  function automatic int rand_below(int n);
    return {$random(seed)} % n;
  endfunction

  function automatic seg_t random_non_hex();
    seg_t seg;
    seg = seg_t'($random(seed));
    while (is_hex(seg))
      seg = seg_t'($random(seed));
    return seg;
  endfunction

  // Fisher-Yates over the sixteen digits
  task automatic shuffle_digits;
    int   j;
    seg_t tmp;
    for (int i = 0; i < 16; i++)
      order[i] = hex_seg[i];
    for (int i = 15; i > 0; i--)
    begin
      j        = rand_below(i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
  endtask

  ////////////////////
  // Driving and checking
  ////////////////////

  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  task automatic report_failure;
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic compare_all;
    logic [DISP_W-1:0] exp_disp;
    logic [MSG_W-1:0]  exp_msg;
    count_t            exp_count;
    for (int k = 0; k < NUM_SLOTS; k++)
    begin
      exp_disp[k*SEG_W +: SEG_W]   = model_seg[k];
      exp_msg[k*CODE_W +: CODE_W]  = model_code[k];
    end
    exp_count = count_t'(model_count);

    assert (display_o === exp_disp)
    else
    begin
      $display("Error: %s display_o expected %h actual %h", test_name, exp_disp, display_o);
      report_failure();
    end
    assert (message_o === exp_msg)
    else
    begin
      $display("Error: %s message_o expected %h actual %h", test_name, exp_msg, message_o);
      report_failure();
    end
    assert (count_o === exp_count)
    else
    begin
      $display("Error: %s count_o expected %0d actual %0d", test_name, exp_count, count_o);
      report_failure();
    end
  endtask

  // One full tick period of command, one of idle, then compare
  task automatic run_command(logic en, logic pr, logic bs, seg_t seg);
    enable_i    = en;
    press_i     = pr;
    backspace_i = bs;
    seg_i       = seg;
    repeat (TICK_PERIOD) next_cycle();
    press_i     = 1'b0;
    backspace_i = 1'b0;
    repeat (TICK_PERIOD) next_cycle();
    update_model(en, pr, bs, seg);
    compare_all();
  endtask

  task automatic apply_reset;
    int waited;
    rst         = 1'b1;
    press_i     = 1'b0;
    backspace_i = 1'b0;
    repeat (RESET_CYCLES) next_cycle();
    rst = 1'b0;
    clear_model();
    waited = 0;
    while (!(count_o == '0 && display_o == '1 && message_o == '0) && waited < WAIT_LIMIT)
    begin
      next_cycle();
      waited++;
    end
    if (waited >= WAIT_LIMIT)
    begin
      $display("Timeout: the buffer did not clear after reset");
      report_failure();
    end
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial
  begin
    int   r;
    int   kind;
    logic en;

    seed        = 32'hee56;
    clk         = 1'b0;
    rst         = 1'b1;
    enable_i    = 1'b0;
    press_i     = 1'b0;
    backspace_i = 1'b0;
    seg_i       = '1;
    init_code_table();

    test_name = "reset";
    apply_reset();
    compare_all();

    test_name = "append";
    shuffle_digits();
    for (int i = 0; i < NUM_SLOTS; i++)
      run_command(1'b1, 1'b1, 1'b0, order[i]);

    test_name = "full buffer";
    run_command(1'b1, 1'b1, 1'b0, random_non_hex());

    test_name = "non-hex append";
    run_command(1'b1, 1'b0, 1'b1, '1);
    run_command(1'b1, 1'b1, 1'b0, random_non_hex());  // Segments kept with a zero code

    test_name = "backspace";
    for (int i = 0; i < NUM_SLOTS; i++)
      run_command(1'b1, 1'b0, 1'b1, '1);
    run_command(1'b1, 1'b0, 1'b1, '1);  // Empty already

    test_name = "append second half";
    for (int i = NUM_SLOTS; i < 16; i++)
      run_command(1'b1, 1'b1, 1'b0, order[i]);

    test_name = "press over backspace";
    run_command(1'b1, 1'b1, 1'b1, order[0]);  // Full buffer so the delete applies
    run_command(1'b1, 1'b0, 1'b1, '1);
    run_command(1'b1, 1'b1, 1'b1, order[3]);

    test_name = "enable gate";
    run_command(1'b0, 1'b1, 1'b0, order[5]);
    run_command(1'b0, 1'b0, 1'b1, '1);
    run_command(1'b0, 1'b1, 1'b1, order[9]);

    test_name = "random run";
    for (int step = 0; step < RANDOM_STEPS; step++)
    begin
      r = rand_below(40);
      if (r == 0)
      begin
        apply_reset();
        compare_all();
      end
      else
      begin
        en   = (rand_below(8) != 0);
        kind = rand_below(8);
        if (kind < 4)
          run_command(en, 1'b1, 1'b0, hex_seg[rand_below(16)]);
        else if (kind == 4)
          run_command(en, 1'b1, 1'b0, random_non_hex());
        else if (kind < 7)
          run_command(en, 1'b0, 1'b1, seg_t'($random(seed)));
        else
          run_command(en, 1'b1, 1'b1, hex_seg[rand_below(16)]);
      end
    end

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: tb.f
hw/morse_pkg.sv
hw/key_tick_gen.sv
hw/seg_to_code.sv
hw/entry_ctrl.sv
hw/char_slot.sv
hw/morse_entry_top.sv
sim/tb_morse_entry.sv
